// ==== src.f ====
common/cart_pkg.sv
msx_slot/msx_slot.sv
logic/io_gpio.sv
ws2812/ws2812_led.sv
logic/cart_top.sv
tb/tb_cart.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and scan the log

verilator --binary --timing --assert --top-module tb_cart -f src.f -o tb_cart \
	&& ./obj_dir/tb_cart > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "SOME TESTS FAILED" sim.log && echo "simulation failed" && exit 1
echo "simulation passed"
exit 0

// ==== tb/tb_cart.sv ====
/* tb_cart : directed testbench for the MSX cartridge I/O subsystem,
   host I/O cycles on the slot pins and a decoder for the WS2812 line */
`timescale 1ns/1ps

module tb_cart;
	localparam logic [7:0]	io_base		= 8'h10;
	localparam int			t0h			= 3;		// short pulse, bit 0
	localparam int			t1h			= 7;		// long pulse, bit 1
	localparam int			bit_len		= 10;
	localparam int			latch_len	= 20;
	localparam int			drive_dly	= 10;		// ns after the rising edge

	logic			clk;
	logic			arst_n;
	logic			slot_iorq_n;
	logic			slot_rd_n;
	logic			slot_wr_n;
	logic [7:0]		slot_a;
	logic [7:0]		d_drv;						// host side of the data bus
	logic			d_oe;
	wire  [7:0]		slot_d;
	logic			slot_data_dir;
	logic			busdir;
	logic			ws2812_led;
	int				errors;

	assign slot_d = d_oe ? d_drv : 8'hzz;

	cart_top #(
		.io_base		( io_base		),
		.t0h_cycles		( t0h			),
		.t1h_cycles		( t1h			),
		.bit_cycles		( bit_len		),
		.latch_cycles	( latch_len		)
	) u_dut (
		.clk42m			( clk			),
		.arst_n			( arst_n		),
		.slot_iorq_n	( slot_iorq_n	),
		.slot_rd_n		( slot_rd_n		),
		.slot_wr_n		( slot_wr_n		),
		.slot_a			( slot_a		),
		.slot_d			( slot_d		),
		.slot_data_dir	( slot_data_dir	),
		.busdir			( busdir		),
		.ws2812_led		( ws2812_led	)
	);

	always #50 clk = ~clk;						// 100 ns period

	// --------------------------------------------------------------------------
	//	compare tasks
	// --------------------------------------------------------------------------
	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			errors++;
			$display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_rgb(input string name, input cart_pkg::rgb_t got,
			input cart_pkg::rgb_t exp);
		if (got !== exp) begin
			errors++;
			$display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	function automatic logic [7:0] port_addr(input cart_pkg::port_sel_e p);
		return io_base + {6'd0, p};				// offset inside the block
	endfunction

	// --------------------------------------------------------------------------
	//	host cycles
	// --------------------------------------------------------------------------
	// let the bridge see both strobes high before the next access
	task automatic settle_bus();
		int n;
		n = 0;
		while (slot_data_dir && n < 16) begin
			@(negedge clk);
			n++;
		end
		if (slot_data_dir) begin
			errors++;
			$display("timeout: slot_data_dir stayed high after the read ended");
		end
		repeat (4) @(posedge clk);
	endtask

	task automatic io_write(input logic [7:0] addr, input logic [7:0] data);
		int i;
		@(posedge clk);
		#drive_dly;
		slot_a		= addr;
		d_drv		= data;
		d_oe		= 1'b1;
		slot_iorq_n	= 1'b0;
		slot_wr_n	= 1'b0;
		for (i = 0; i < 8; i++) begin
			@(negedge clk);
			check_bit("busdir", busdir, 1'b0);		// never turns on a write
		end
		@(posedge clk);
		#drive_dly;
		slot_iorq_n	= 1'b1;
		slot_wr_n	= 1'b1;
		d_oe		= 1'b0;
		settle_bus();
	endtask

	// data is taken once slot_data_dir shows the bridge driving
	task automatic io_read(input logic [7:0] addr, output logic [7:0] data,
			output logic saw_busdir, output logic saw_dir);
		int i;
		data		= 8'hxx;
		saw_busdir	= 1'b0;
		saw_dir		= 1'b0;
		@(posedge clk);
		#drive_dly;
		slot_a		= addr;
		slot_iorq_n	= 1'b0;
		slot_rd_n	= 1'b0;
		for (i = 0; i < 8; i++) begin
			@(negedge clk);
			saw_busdir = saw_busdir | busdir;
			if (slot_data_dir) begin
				saw_dir	= 1'b1;
				data	= slot_d;
			end
		end
		@(posedge clk);
		#drive_dly;
		slot_iorq_n	= 1'b1;
		slot_rd_n	= 1'b1;
		settle_bus();
	endtask

	// poll the ctrl port until the busy bit drops
	task automatic wait_led_idle(output logic [7:0] status);
		logic	sb;
		logic	sd;
		int		tries;
		status	= 8'h01;
		tries	= 0;
		while (status[0] !== 1'b0 && tries < 20) begin
			io_read(port_addr(cart_pkg::port_ctrl), status, sb, sd);
			tries++;
		end
		if (status[0] !== 1'b0) begin
			errors++;
			$display("timeout: the LED stayed busy after the frame");
		end
	endtask

	// --------------------------------------------------------------------------
	//	LED decoder, 24 pulse widths into GRB
	// --------------------------------------------------------------------------
	task automatic led_capture(output cart_pkg::rgb_t frame);
		logic [23:0]	bits;
		int				n;
		int				width;
		int				idle;
		bits = '0;
		for (n = 0; n < 24; n++) begin
			idle = 0;
			while (!ws2812_led && idle < 100) begin	// wait for the rising edge
				@(negedge clk);
				idle++;
			end
			if (!ws2812_led) begin
				errors++;
				$display("timeout: pulse %0d of the LED frame never started", n);
				break;
			end
			width = 0;
			while (ws2812_led && width <= bit_len) begin
				width++;
				@(negedge clk);
			end
			if (width == t1h) begin
				bits = {bits[22:0], 1'b1};
			end else if (width == t0h) begin
				bits = {bits[22:0], 1'b0};
			end else begin
				errors++;
				$display("pulse %0d is %0d cycles wide, neither a 0 nor a 1", n, width);
			end
		end
		frame.green	= bits[23:16];				// sent first
		frame.red	= bits[15:8];
		frame.blue	= bits[7:0];
	endtask

	// --------------------------------------------------------------------------
	//	tests
	// --------------------------------------------------------------------------
	task automatic reset_state();
		logic [7:0]	rd;
		logic		sb;
		logic		sd;
		check_bit("ws2812_led", ws2812_led, 1'b0);
		check_bit("slot_data_dir", slot_data_dir, 1'b0);
		check_bit("busdir", busdir, 1'b0);
		io_read(port_addr(cart_pkg::port_red), rd, sb, sd);
		check_byte("red after reset", rd, 8'h00);
		io_read(port_addr(cart_pkg::port_green), rd, sb, sd);
		check_byte("green after reset", rd, 8'h00);
		io_read(port_addr(cart_pkg::port_blue), rd, sb, sd);
		check_byte("blue after reset", rd, 8'h00);
	endtask

	task automatic reg_readback(output cart_pkg::rgb_t col);
		logic [7:0]	rd;
		logic		sb;
		logic		sd;
		col.red		= 8'($urandom);
		col.green	= 8'($urandom);
		col.blue	= 8'($urandom);
		io_write(port_addr(cart_pkg::port_red), col.red);
		io_write(port_addr(cart_pkg::port_green), col.green);
		io_write(port_addr(cart_pkg::port_blue), col.blue);
		io_read(port_addr(cart_pkg::port_red), rd, sb, sd);
		check_byte("red readback", rd, col.red);
		check_bit("busdir", sb, 1'b1);
		check_bit("slot_data_dir", sd, 1'b1);
		io_read(port_addr(cart_pkg::port_green), rd, sb, sd);
		check_byte("green readback", rd, col.green);
		io_read(port_addr(cart_pkg::port_blue), rd, sb, sd);
		check_byte("blue readback", rd, col.blue);
	endtask

	// neighbours of the block on both sides, low bits alias each colour
	task automatic port_decode(input cart_pkg::rgb_t col);
		logic [7:0]	rd;
		logic		sb;
		logic		sd;
		io_write(io_base + 8'd4, ~col.red);
		io_write(io_base + 8'd5, ~col.green);
		io_write(io_base - 8'd2, ~col.blue);
		io_read(io_base + 8'd4, rd, sb, sd);
		check_bit("busdir", sb, 1'b0);
		check_bit("slot_data_dir", sd, 1'b0);
		io_read(io_base - 8'd2, rd, sb, sd);
		check_bit("busdir", sb, 1'b0);
		check_bit("slot_data_dir", sd, 1'b0);
		io_read(port_addr(cart_pkg::port_red), rd, sb, sd);
		check_byte("red after foreign ports", rd, col.red);
		io_read(port_addr(cart_pkg::port_green), rd, sb, sd);
		check_byte("green after foreign ports", rd, col.green);
		io_read(port_addr(cart_pkg::port_blue), rd, sb, sd);
		check_byte("blue after foreign ports", rd, col.blue);
	endtask

	task automatic led_frame(input cart_pkg::rgb_t col);
		cart_pkg::rgb_t	got;
		fork
			io_write(port_addr(cart_pkg::port_ctrl), 8'h01);
			led_capture(got);
		join
		check_rgb("led frame", got, col);
	endtask

	task automatic busy_and_drop(input cart_pkg::rgb_t col);
		cart_pkg::rgb_t	got;
		cart_pkg::rgb_t	next;
		logic [7:0]		busy;
		logic [7:0]		rd;
		logic			sb;
		logic			sd;
		next		= col;
		next.red	= col.red ^ 8'h5a;
		wait_led_idle(rd);						// previous frame and its latch gap
		fork
			begin
				io_write(port_addr(cart_pkg::port_ctrl), 8'h01);
				io_read(port_addr(cart_pkg::port_ctrl), busy, sb, sd);
				io_write(port_addr(cart_pkg::port_red), next.red);
				io_write(port_addr(cart_pkg::port_ctrl), 8'h01);	// dropped, busy
			end
			led_capture(got);
		join
		check_byte("ctrl status in frame", busy, 8'h01);
		check_bit("sending", busy[0], 1'b1);
		check_rgb("frame with dropped send", got, col);
		wait_led_idle(rd);
		check_byte("ctrl status after frame", rd, 8'h00);
		led_frame(next);						// new red goes out now
	endtask

	// --------------------------------------------------------------------------
	//	main sequence
	// --------------------------------------------------------------------------
	initial begin
		cart_pkg::rgb_t	col;
		clk			= 1'b0;
		arst_n		= 1'b0;
		slot_iorq_n	= 1'b1;
		slot_rd_n	= 1'b1;
		slot_wr_n	= 1'b1;
		slot_a		= 8'h00;
		d_drv		= 8'h00;
		d_oe		= 1'b0;
		errors		= 0;
		void'($urandom(32'h7ed6));
		repeat (4) @(posedge clk);
		#drive_dly;
		arst_n		= 1'b1;
		reset_state();
		reg_readback(col);
		port_decode(col);
		led_frame(col);
		busy_and_drop(col);
		$display("checks done, %0d errors", errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== logic/cart_top.sv ====
/* cart_top : MSX cartridge I/O subsystem, slot bridge, GPIO colour registers
   and WS2812 serializer on the clk42m domain */
`timescale 1ns/1ps

module cart_top #(
	parameter logic [7:0]	io_base			= 8'h10,
	parameter int			t0h_cycles		= 17,
	parameter int			t1h_cycles		= 34,
	parameter int			bit_cycles		= 54,
	parameter int			latch_cycles	= 2200
) (
	input  logic		clk42m,				// 42.95454MHz
	input  logic		arst_n,
	input  logic		slot_iorq_n,
	input  logic		slot_rd_n,
	input  logic		slot_wr_n,
	input  logic [7:0]	slot_a,
	inout  wire  [7:0]	slot_d,
	output logic		slot_data_dir,
	output logic		busdir,
	output logic		ws2812_led
);
	cart_pkg::bus_req_t	w_bus_req;
	cart_pkg::bus_rsp_t	w_bus_rsp;
	logic				w_led_wr;
	cart_pkg::rgb_t		w_led_rgb;
	logic				w_led_sending;

	// --------------------------------------------------------------------------
	//	slot bridge
	// --------------------------------------------------------------------------
	msx_slot #(
		.io_base			( io_base			)
	) u_msx_slot (
		.clk				( clk42m			),
		.arst_n				( arst_n			),
		.slot_iorq_n		( slot_iorq_n		),
		.slot_rd_n			( slot_rd_n			),
		.slot_wr_n			( slot_wr_n			),
		.slot_a				( slot_a			),
		.rsp				( w_bus_rsp			),
		.slot_d				( slot_d			),
		.slot_data_dir		( slot_data_dir		),
		.busdir				( busdir			),
		.req				( w_bus_req			)
	);

	// GPIO, colour and ctrl ports
	io_gpio u_gpio (
		.clk				( clk42m			),
		.arst_n				( arst_n			),
		.req				( w_bus_req			),
		.sending			( w_led_sending		),
		.rsp				( w_bus_rsp			),
		.led_wr				( w_led_wr			),
		.led_rgb			( w_led_rgb			)
	);

	// --------------------------------------------------------------------------
	//	full-colour LED
	// --------------------------------------------------------------------------
	ws2812_led #(
		.t0h_cycles			( t0h_cycles		),
		.t1h_cycles			( t1h_cycles		),
		.bit_cycles			( bit_cycles		),
		.latch_cycles		( latch_cycles		)
	) u_led (
		.clk				( clk42m			),
		.arst_n				( arst_n			),
		.wr					( w_led_wr			),
		.rgb				( w_led_rgb			),
		.sending			( w_led_sending		),
		.ws2812_led			( ws2812_led		)
	);

endmodule

// ==== ws2812/ws2812_led.sv ====
/* ws2812_led : WS2812 serializer, 24 bits GRB MSB first as pulse-width bits,
   followed by a low latch gap; colour is taken at frame start */
`timescale 1ns/1ps

module ws2812_led #(
	parameter int	t0h_cycles		= 17,		// ~0.4us at 42.95MHz
	parameter int	t1h_cycles		= 34,		// ~0.8us
	parameter int	bit_cycles		= 54,		// ~1.25us per bit
	parameter int	latch_cycles	= 2200		// >50us reset gap
) (
	input  logic			clk,
	input  logic			arst_n,
	input  logic			wr,				// start pulse
	input  cart_pkg::rgb_t	rgb,
	output logic			sending,
	output logic			ws2812_led
);
	// counter has to reach the longer of bit period and latch gap
	localparam int cnt_max	= (latch_cycles > bit_cycles) ? latch_cycles : bit_cycles;
	localparam int cnt_w	= $clog2(cnt_max + 1);

	cart_pkg::led_state_e	state;
	logic [23:0]			shift;			// current bit in [23]
	logic [4:0]				bit_cnt;		// 0..23
	logic [cnt_w-1:0]		cnt;			// cycles within bit / gap
	logic [cnt_w-1:0]		high_len;
	logic					bit_end;
	logic					start;
	logic					led_q;

	assign high_len	= shift[23] ? cnt_w'(t1h_cycles) : cnt_w'(t0h_cycles);
	assign bit_end	= (state == cart_pkg::st_low) && (cnt == cnt_w'(bit_cycles - 1));
	assign start	= (state == cart_pkg::st_idle) && wr;	// wr while busy is dropped

	// --------------------------------------------------------------------------
	//	frame FSM
	// --------------------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state	<= cart_pkg::st_idle;
			bit_cnt	<= '0;
			cnt		<= '0;
			led_q	<= 1'b0;
		end else begin
			case (state)
				cart_pkg::st_idle: begin
					if (start) begin
						state	<= cart_pkg::st_high;
						led_q	<= 1'b1;			// first bit starts right away
						cnt		<= '0;
						bit_cnt	<= '0;
					end
				end
				cart_pkg::st_high: begin
					cnt <= cnt + 1'b1;				// keeps counting into st_low
					if (cnt == high_len - 1'b1) begin
						state	<= cart_pkg::st_low;
						led_q	<= 1'b0;
					end
				end
				cart_pkg::st_low: begin
					if (bit_end) begin
						cnt <= '0;
						if (bit_cnt == 5'd23) begin
							state	<= cart_pkg::st_latch;	// all 24 out
						end else begin
							bit_cnt	<= bit_cnt + 1'b1;
							state	<= cart_pkg::st_high;
							led_q	<= 1'b1;
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				cart_pkg::st_latch: begin
					if (cnt == cnt_w'(latch_cycles - 1)) begin
						state	<= cart_pkg::st_idle;	// gap done, ready again
					end else begin
						cnt		<= cnt + 1'b1;
					end
				end
				default: begin
					state <= cart_pkg::st_idle;
				end
			endcase
		end
	end

	// GRB order, MSB first
	always_ff @(posedge clk) begin
		if (start) begin
			shift <= {rgb.green, rgb.red, rgb.blue};
		end else if (bit_end) begin
			shift <= {shift[22:0], 1'b0};
		end
	end

	assign sending		= (state != cart_pkg::st_idle);
	assign ws2812_led	= led_q;			// registered, no decode glitches

	// --------------------------------------------------------------------------
	//	checks
	// --------------------------------------------------------------------------
	a_led_in_frame: assert property (@(posedge clk) disable iff (!arst_n)
		ws2812_led |-> sending);

endmodule

// ==== logic/io_gpio.sv ====
/* io_gpio : colour registers and control/status port for the WS2812 LED
   write to the ctrl port starts a frame, reads return registers or busy */
`timescale 1ns/1ps

module io_gpio (
	input  logic				clk,
	input  logic				arst_n,
	input  cart_pkg::bus_req_t	req,
	input  logic				sending,		// LED frame in progress
	output cart_pkg::bus_rsp_t	rsp,
	output logic				led_wr,
	output cart_pkg::rgb_t		led_rgb
);
	logic		wr_hit;
	logic		rd_hit;
	logic		rdata_en;
	logic [7:0]	rdata;
	logic [7:0]	rd_mux;

	assign wr_hit = req.valid && req.write;
	assign rd_hit = req.valid && !req.write;

	// --------------------------------------------------------------------------
	//	registers
	// --------------------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			led_rgb	<= '0;
			led_wr	<= 1'b0;
		end else begin
			led_wr	<= wr_hit && (req.port == cart_pkg::port_ctrl);	// send pulse
			if (wr_hit) begin
				case (req.port)
					cart_pkg::port_red:		led_rgb.red		<= req.wdata;
					cart_pkg::port_green:	led_rgb.green	<= req.wdata;
					cart_pkg::port_blue:	led_rgb.blue	<= req.wdata;
					default: begin
						// ctrl write carries no data, only the pulse above
					end
				endcase
			end
		end
	end

	// --------------------------------------------------------------------------
	//	read path
	// --------------------------------------------------------------------------
	always_comb begin
		case (req.port)
			cart_pkg::port_red:		rd_mux = led_rgb.red;
			cart_pkg::port_green:	rd_mux = led_rgb.green;
			cart_pkg::port_blue:	rd_mux = led_rgb.blue;
			default:				rd_mux = {7'd0, sending};	// bit0 busy
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rdata_en <= 1'b0;
		end else begin
			rdata_en <= rd_hit;				// answer one cycle later
		end
	end

	always_ff @(posedge clk) begin
		if (rd_hit) begin
			rdata <= rd_mux;
		end
	end

	assign rsp = '{rdata_en: rdata_en, rdata: rdata};

	// response only follows a read
	a_rsp_after_read: assert property (@(posedge clk) disable iff (!arst_n)
		rsp.rdata_en |-> $past(rd_hit));

	// an idle serializer takes the send pulse at once
	a_send_accepted: assert property (@(posedge clk) disable iff (!arst_n)
		led_wr && !sending |=> sending);

endmodule

// ==== msx_slot/msx_slot.sv ====
/* msx_slot : MSX slot I/O bridge, syncs the Z80 strobes, decodes the port block
   into single-cycle bus requests and drives slot_d back on reads */
`timescale 1ns/1ps

module msx_slot #(
	parameter logic [7:0]	io_base = 8'h10		// base of the 4-port block
) (
	input  logic				clk,
	input  logic				arst_n,
	input  logic				slot_iorq_n,
	input  logic				slot_rd_n,
	input  logic				slot_wr_n,
	input  logic [7:0]			slot_a,
	input  cart_pkg::bus_rsp_t	rsp,
	inout  wire  [7:0]			slot_d,
	output logic				slot_data_dir,
	output logic				busdir,
	output cart_pkg::bus_req_t	req
);
	logic [1:0]				iorq_sync;		// raw pin samples, [1] is safe to use
	logic [1:0]				rd_sync;
	logic [1:0]				wr_sync;
	logic					access_s;		// synced: iorq plus rd or wr low
	logic					access_d;
	logic					access_start;
	logic					in_range;

	logic					req_valid;
	logic					req_write;
	cart_pkg::port_sel_e	req_port;
	logic [7:0]				req_wdata;
	logic [7:0]				rd_latch;		// read data held for the host
	cart_pkg::slot_state_e	state;

	// --------------------------------------------------------------------------
	//	strobe synchronizer and edge detect
	// --------------------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			iorq_sync	<= 2'b11;			// strobes idle high
			rd_sync		<= 2'b11;
			wr_sync		<= 2'b11;
			access_d	<= 1'b0;
		end else begin
			iorq_sync	<= {iorq_sync[0], slot_iorq_n};
			rd_sync		<= {rd_sync[0], slot_rd_n};
			wr_sync		<= {wr_sync[0], slot_wr_n};
			access_d	<= access_s;
		end
	end

	assign access_s		= !iorq_sync[1] && (!rd_sync[1] || !wr_sync[1]);
	assign access_start	= access_s && !access_d;	// 2 cycles after the pin edge

	// block decode, low two bits pick the port
	assign in_range		= (slot_a[7:2] == io_base[7:2]);

	// straight from the pins so the external buffer turns before data is due
	assign busdir		= !slot_iorq_n && !slot_rd_n && in_range;

	// --------------------------------------------------------------------------
	//	access FSM
	// --------------------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state			<= cart_pkg::sl_idle;
			req_valid		<= 1'b0;
			slot_data_dir	<= 1'b0;
		end else begin
			req_valid <= 1'b0;						// single-cycle strobe
			case (state)
				cart_pkg::sl_idle: begin
					if (access_start && in_range) begin
						req_valid	<= 1'b1;		// third edge after the strobe
						state		<= cart_pkg::sl_access;
					end else if (access_start) begin
						state		<= cart_pkg::sl_wait_end;	// not ours, just sit it out
					end
				end
				cart_pkg::sl_access: begin
					state <= cart_pkg::sl_wait_end;
				end
				cart_pkg::sl_wait_end: begin
					if (rsp.rdata_en) begin
						slot_data_dir <= 1'b1;		// start driving slot_d
					end
					if (!access_s) begin
						state <= cart_pkg::sl_idle;	// both strobes back high
					end
				end
				default: begin
					state <= cart_pkg::sl_idle;
				end
			endcase
			if (rd_sync[1]) begin
				slot_data_dir <= 1'b0;				// host let go of rd
			end
		end
	end

	// payload capture, address and data are stable by the time the edge is seen
	always_ff @(posedge clk) begin
		if (state == cart_pkg::sl_idle && access_start) begin
			req_write	<= !wr_sync[1];
			req_port	<= cart_pkg::port_sel_e'(slot_a[1:0]);
			req_wdata	<= slot_d;
		end
		if (rsp.rdata_en) begin
			rd_latch	<= rsp.rdata;
		end
	end

	assign req = '{valid: req_valid, write: req_write, port: req_port, wdata: req_wdata};

	// tristate towards the slot
	assign slot_d = slot_data_dir ? rd_latch : 8'hzz;

	// one request per host cycle
	a_single_valid: assert property (@(posedge clk) disable iff (!arst_n)
		req.valid |=> !req.valid);

endmodule

// ==== common/cart_pkg.sv ====
/* cart_pkg : shared types for the MSX cartridge I/O subsystem
   internal bus request/response, LED colour, port select and FSM states */

package cart_pkg;

	// --------------------------------------------------------------------------
	//	port offsets inside the decoded 4-port block
	// --------------------------------------------------------------------------
	typedef enum logic [1:0] {
		port_red	= 2'd0,		// io_base+0
		port_green	= 2'd1,		// io_base+1
		port_blue	= 2'd2,		// io_base+2
		port_ctrl	= 2'd3		// io_base+3, send / status
	} port_sel_e;

	// one access from the slot bridge, valid is a single-cycle strobe
	typedef struct packed {
		logic		valid;
		logic		write;		// 1 = OUT, 0 = IN
		port_sel_e	port;
		logic [7:0]	wdata;
	} bus_req_t;

	// read answer, rdata only meaningful with rdata_en
	typedef struct packed {
		logic		rdata_en;
		logic [7:0]	rdata;
	} bus_rsp_t;

	typedef struct packed {
		logic [7:0]	red;
		logic [7:0]	green;
		logic [7:0]	blue;
	} rgb_t;

	// --------------------------------------------------------------------------
	//	FSM states
	// --------------------------------------------------------------------------
	typedef enum logic [1:0] {
		sl_idle,			// waiting for a strobe
		sl_access,			// request out this cycle
		sl_wait_end			// hold until host releases strobes
	} slot_state_e;

	typedef enum logic [1:0] {
		st_idle,
		st_high,			// pulse part of a bit
		st_low,				// rest of the bit period
		st_latch			// reset gap after 24 bits
	} led_state_e;

endpackage
